// ==== src/sa_macros.svh ====
`ifndef SA_MACROS_SVH
`define SA_MACROS_SVH

// ============================================================
// Row geometry
// ============================================================
`define SA_NUM_PE      4
`define SA_IDX_W       ($clog2(`SA_NUM_PE))

// ============================================================
// Data widths
// ============================================================
`define SA_ACT_W       8
`define SA_WGT_W       8
`define SA_CHN_W       16
`define SA_PSUM_W      (`SA_ACT_W + `SA_WGT_W + `SA_CHN_W)

// West-edge buffering
`define SA_FIFO_DEPTH  4

`endif

// ==== src/saDataPkg.sv ====
`include "sa_macros.svh"

package saDataPkg;

    // Operand types
    typedef logic signed [`SA_ACT_W-1:0]  actT;
    typedef logic signed [`SA_WGT_W-1:0]  wgtT;

    // Accumulator wide enough for the channel growth
    typedef logic signed [`SA_PSUM_W-1:0] psumT;

    // Requantized output and element index
    typedef logic [`SA_ACT_W-1:0] qOutT;
    typedef logic [`SA_IDX_W-1:0] peIdxT;

    // Per-element bundles across the row
    typedef wgtT  [`SA_NUM_PE-1:0] wgtVecT;
    typedef psumT [`SA_NUM_PE-1:0] psumVecT;

    // Element FSM
    typedef enum logic {
        PE_ACCUM = 1'b0,
        PE_HOLD  = 1'b1
    } peStateT;

endpackage

// ==== src/saCfgPkg.sv ====
package saCfgPkg;

    // Right shift applied before truncation
    typedef logic [4:0] shiftT;

    // Output zero point, added modulo 256
    typedef logic [7:0] zpT;

    typedef struct packed {
        shiftT shift;
        zpT    zp;
    } requantCfgT;

endpackage

// ==== src/actStreamIf.sv ====
`timescale 1ns/1ns

// Activation stream with valid/ready handshake
interface actStreamIf;

    logic           vld;
    logic           chnLast;
    saDataPkg::actT data;
    logic           rdy;

    // Producer side
    modport source (
        output vld,
        output chnLast,
        output data,
        input  rdy
    );

    // Consumer side
    modport sink (
        input  vld,
        input  chnLast,
        input  data,
        output rdy
    );

endinterface

// ==== src/actInputFifo.sv ====
`timescale 1ns/1ns
`include "sa_macros.svh"

module actInputFifo (
    input  logic           clk,
    input  logic           rstN,
    input  logic           actInVld,
    input  logic           actInChnLast,
    input  saDataPkg::actT actIn,
    output logic           actInRdy,
    actStreamIf.source     outStream
);

    localparam int Depth = `SA_FIFO_DEPTH;
    localparam int PtrW  = $clog2(Depth);

    saDataPkg::actT  memData [Depth];
    logic            memLast [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   count;
    logic [PtrW:0]   countNext;
    logic            wrEn;
    logic            rdEn;

    assign wrEn = actInVld && actInRdy;
    assign rdEn = outStream.vld && outStream.rdy;

    always_comb begin
        countNext = count;
        if (wrEn && !rdEn) begin
            countNext = count + 1'b1;
        end else if (rdEn && !wrEn) begin
            countNext = count - 1'b1;
        end
    end

    // Pointers, occupancy and registered ready (low while full)
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            actInRdy <= 1'b0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count    <= countNext;
            actInRdy <= (countNext != (PtrW + 1)'(Depth));
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wrEn) begin
            memData[wrPtr] <= actIn;
            memLast[wrPtr] <= actInChnLast;
        end
    end

    // Head of queue shown directly
    assign outStream.vld     = (count != '0);
    assign outStream.data    = memData[rdPtr];
    assign outStream.chnLast = memLast[rdPtr];

endmodule

// ==== src/processingElement.sv ====
`timescale 1ns/1ns

module processingElement (
    input  logic            clk,
    input  logic            rstN,
    actStreamIf.sink        west,
    actStreamIf.source      east,
    input  logic            wgtVld,
    input  saDataPkg::wgtT  wgt,
    output logic            wgtRdy,
    output logic            psumVld,
    output saDataPkg::psumT psum,
    input  logic            psumRdy
);

    saDataPkg::peStateT state;
    saDataPkg::psumT    acc;
    saDataPkg::psumT    prod;
    saDataPkg::psumT    accSum;
    saDataPkg::psumT    psumR;
    saDataPkg::actT     eastData;
    logic               eastLast;
    logic               eastVld;
    logic               fire;

    // ============================================================
    // Fire condition
    // ============================================================
    // East slot free now or emptied this cycle
    assign fire = west.vld && wgtVld && (state == saDataPkg::PE_ACCUM)
                  && (!eastVld || east.rdy);

    assign west.rdy = fire;
    assign wgtRdy   = fire;

    // Signed product sign extended to accumulator width
    assign prod   = saDataPkg::psumT'(west.data) * saDataPkg::psumT'(wgt);
    assign accSum = acc + prod;

    // ============================================================
    // Window FSM and accumulator
    // ============================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= saDataPkg::PE_ACCUM;
            acc   <= '0;
        end else begin
            case (state)
                saDataPkg::PE_ACCUM: begin
                    if (fire) begin
                        // Last channel closes the window
                        acc <= west.chnLast ? '0 : accSum;
                        if (west.chnLast) begin
                            state <= saDataPkg::PE_HOLD;
                        end
                    end
                end
                saDataPkg::PE_HOLD: begin
                    if (psumRdy) begin
                        state <= saDataPkg::PE_ACCUM;
                    end
                end
                default: begin
                    state <= saDataPkg::PE_ACCUM;
                end
            endcase
        end
    end

    // Finished window result
    always_ff @(posedge clk) begin
        if (fire && west.chnLast) begin
            psumR <= accSum;
        end
    end

    assign psumVld = (state == saDataPkg::PE_HOLD);
    assign psum    = psumR;

    // ============================================================
    // East forwarding register
    // ============================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            eastVld <= 1'b0;
        end else if (fire) begin
            eastVld <= 1'b1;
        end else if (east.rdy) begin
            eastVld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            eastData <= west.data;
            eastLast <= west.chnLast;
        end
    end

    assign east.vld     = eastVld;
    assign east.data    = eastData;
    assign east.chnLast = eastLast;

endmodule

// ==== src/peRow.sv ====
`timescale 1ns/1ns
`include "sa_macros.svh"

module peRow (
    input  logic                  clk,
    input  logic                  rstN,
    actStreamIf.sink              west,
    actStreamIf.source            east,
    input  logic [`SA_NUM_PE-1:0] wgtVld,
    input  saDataPkg::wgtVecT     wgt,
    output logic [`SA_NUM_PE-1:0] wgtRdy,
    output logic [`SA_NUM_PE-1:0] psumVld,
    output saDataPkg::psumVecT    psum,
    input  logic [`SA_NUM_PE-1:0] psumRdy
);

    // Link i feeds element i, link i+1 takes its east output
    actStreamIf link [0:`SA_NUM_PE] ();

    // ============================================================
    // Row boundaries
    // ============================================================
    assign link[0].vld     = west.vld;
    assign link[0].chnLast = west.chnLast;
    assign link[0].data    = west.data;
    assign west.rdy        = link[0].rdy;

    assign east.vld                = link[`SA_NUM_PE].vld;
    assign east.chnLast            = link[`SA_NUM_PE].chnLast;
    assign east.data               = link[`SA_NUM_PE].data;
    assign link[`SA_NUM_PE].rdy    = east.rdy;

    // ============================================================
    // Element chain
    // ============================================================
    for (genvar i = 0; i < `SA_NUM_PE; i++) begin : gPe
        processingElement processingElement_i (
            .clk     (clk),
            .rstN    (rstN),
            .west    (link[i]),
            .east    (link[i+1]),
            .wgtVld  (wgtVld[i]),
            .wgt     (wgt[i]),
            .wgtRdy  (wgtRdy[i]),
            .psumVld (psumVld[i]),
            .psum    (psum[i]),
            .psumRdy (psumRdy[i])
        );
    end

endmodule

// ==== src/psumRequant.sv ====
`timescale 1ns/1ns
`include "sa_macros.svh"

module psumRequant (
    input  logic                  clk,
    input  logic                  rstN,
    input  saCfgPkg::requantCfgT  cfg,
    input  logic [`SA_NUM_PE-1:0] inVld,
    output logic [`SA_NUM_PE-1:0] inRdy,
    input  saDataPkg::psumVecT    inPsum,
    output logic                  psumVld,
    output saDataPkg::qOutT       psumQ,
    output saDataPkg::peIdxT      psumIdx,
    input  logic                  psumRdy
);

    saDataPkg::peIdxT lastGnt;
    saDataPkg::peIdxT gntIdx;
    logic             gntFound;
    logic             take;

    // Negative clamps to zero, otherwise shift, truncate and offset
    function automatic saDataPkg::qOutT requant(saDataPkg::psumT p, saCfgPkg::requantCfgT c);
        saDataPkg::psumT shifted;
        shifted = p >>> c.shift;
        if (p[`SA_PSUM_W-1]) begin
            return '0;
        end
        return shifted[`SA_ACT_W-1:0] + c.zp;
    endfunction

    // ============================================================
    // Round-robin search from one past the last grant
    // ============================================================
    always_comb begin
        int unsigned cand;
        gntFound = 1'b0;
        gntIdx   = lastGnt;
        for (int off = 1; off <= `SA_NUM_PE; off++) begin
            cand = (int'(lastGnt) + off) % `SA_NUM_PE;
            if (!gntFound && inVld[cand]) begin
                gntFound = 1'b1;
                gntIdx   = saDataPkg::peIdxT'(cand);
            end
        end
    end

    // Collect only when the output stage can take it
    assign take = gntFound && (!psumVld || psumRdy);

    always_comb begin
        inRdy = '0;
        if (take) begin
            inRdy[gntIdx] = 1'b1;
        end
    end

    // ============================================================
    // Output stage
    // ============================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            psumVld <= 1'b0;
            lastGnt <= saDataPkg::peIdxT'(`SA_NUM_PE - 1);
        end else if (take) begin
            psumVld <= 1'b1;
            lastGnt <= gntIdx;
        end else if (psumRdy) begin
            psumVld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            psumQ   <= requant(inPsum[gntIdx], cfg);
            psumIdx <= gntIdx;
        end
    end

endmodule

// ==== src/systolicRowTop.sv ====
`timescale 1ns/1ns
`include "sa_macros.svh"

module systolicRowTop (
    input  logic                  clk,
    input  logic                  rstN,
    input  saCfgPkg::shiftT       cfgShift,
    input  saCfgPkg::zpT          cfgZp,
    input  logic                  actInVld,
    input  logic                  actInChnLast,
    input  saDataPkg::actT        actIn,
    output logic                  actInRdy,
    output logic                  actOutVld,
    output logic                  actOutChnLast,
    output saDataPkg::actT        actOut,
    input  logic                  actOutRdy,
    input  logic [`SA_NUM_PE-1:0] wgtVld,
    input  saDataPkg::wgtVecT     wgt,
    output logic [`SA_NUM_PE-1:0] wgtRdy,
    output logic                  psumVld,
    output saDataPkg::qOutT       psumQ,
    output saDataPkg::peIdxT      psumIdx,
    input  logic                  psumRdy
);

    saCfgPkg::requantCfgT         cfg;
    logic [`SA_NUM_PE-1:0]        rowPsumVld;
    logic [`SA_NUM_PE-1:0]        rowPsumRdy;
    saDataPkg::psumVecT           rowPsum;

    actStreamIf fifoStream ();
    actStreamIf eastStream ();

    assign cfg.shift = cfgShift;
    assign cfg.zp    = cfgZp;

    // ============================================================
    // West buffer, element chain, drain
    // ============================================================
    actInputFifo actInputFifo_i (
        .clk          (clk),
        .rstN         (rstN),
        .actInVld     (actInVld),
        .actInChnLast (actInChnLast),
        .actIn        (actIn),
        .actInRdy     (actInRdy),
        .outStream    (fifoStream)
    );

    peRow peRow_i (
        .clk     (clk),
        .rstN    (rstN),
        .west    (fifoStream),
        .east    (eastStream),
        .wgtVld  (wgtVld),
        .wgt     (wgt),
        .wgtRdy  (wgtRdy),
        .psumVld (rowPsumVld),
        .psum    (rowPsum),
        .psumRdy (rowPsumRdy)
    );

    psumRequant psumRequant_i (
        .clk     (clk),
        .rstN    (rstN),
        .cfg     (cfg),
        .inVld   (rowPsumVld),
        .inRdy   (rowPsumRdy),
        .inPsum  (rowPsum),
        .psumVld (psumVld),
        .psumQ   (psumQ),
        .psumIdx (psumIdx),
        .psumRdy (psumRdy)
    );

    // East edge out to the next row
    assign actOutVld      = eastStream.vld;
    assign actOutChnLast  = eastStream.chnLast;
    assign actOut         = eastStream.data;
    assign eastStream.rdy = actOutRdy;

endmodule

// ==== testbench/tbVectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One row per window
// Fields in order are the length, the activations (byte k is channel k), the
// weights per element (same packing, element 0 first), shift, zp, the stall
// enables (bit 0 psumRdy, bit 1 actOutRdy) and the expected psumQ per element
typedef struct packed {
    logic [3:0]                              len;
    logic [63:0]                             act;
    logic [0:`SA_NUM_PE-1][63:0]             wgt;
    saCfgPkg::shiftT                         shift;
    saCfgPkg::zpT                            zp;
    logic [1:0]                              stall;
    saDataPkg::qOutT [0:`SA_NUM_PE-1]        expQ;
} vecRowT;

localparam int NumVec = 6;

string vecName [NumVec] = '{
    "posBasic", "negClamp", "singleChannel", "psumStall", "actStall", "bothStall"
};

vecRowT vecTable [NumVec] = '{
    '{4'd3, 64'h0000_0000_0003_0201,
      '{64'h0000_0000_0001_0101, 64'h0000_0000_0002_0202,
        64'h0000_0000_000A_0A0A, 64'h0000_0000_0004_FF03},
      5'd1, 8'h05, 2'b00, '{8'h08, 8'h0B, 8'h23, 8'h0B}},
    // Zero point wraps past 255 on element 3
    '{4'd4, 64'h0000_0000_0207_FD05,
      '{64'h0000_0000_FFFF_FFFF, 64'h0000_0000_0101_0101,
        64'h0000_0000_0000_0A00, 64'h0000_0000_0000_0014},
      5'd0, 8'hC8, 2'b00, '{8'h00, 8'hD3, 8'h00, 8'h2C}},
    '{4'd1, 64'h0000_0000_0000_0080,
      '{64'h0000_0000_0000_0080, 64'h0000_0000_0000_0001,
        64'h0000_0000_0000_00FF, 64'h0000_0000_0000_007F},
      5'd7, 8'h03, 2'b00, '{8'h83, 8'h00, 8'h04, 8'h00}},
    '{4'd5, 64'h0000_0032_281E_140A,
      '{64'h0000_0001_0101_0101, 64'h0000_0000_0000_0002,
        64'h0000_00FF_0000_0000, 64'h0000_0064_6464_6464},
      5'd2, 8'h10, 2'b01, '{8'h35, 8'h15, 8'h00, 8'hB6}},
    '{4'd8, 64'h0807_0605_0403_0201,
      '{64'h0101_0101_0101_0101, 64'hFFFF_FFFF_FFFF_FFFF,
        64'h0102_0304_0506_0708, 64'h7F7F_7F7F_7F7F_7F7F},
      5'd0, 8'h00, 2'b10, '{8'h24, 8'h00, 8'h78, 8'hDC}},
    '{4'd6, 64'h0000_FAFB_FCFD_FEFF,
      '{64'h0000_FEFE_FEFE_FEFE, 64'h0000_0303_0303_0303,
        64'h0000_9C9C_9C9C_9C9C, 64'h0000_8000_0000_0000},
      5'd3, 8'h80, 2'b11, '{8'h85, 8'h00, 8'h86, 8'hE0}}
};

`endif

// ==== testbench/tbSystolicRow.sv ====
`timescale 1ns/1ns
`include "sa_macros.svh"

module tbSystolicRow;

    localparam int NumPe = `SA_NUM_PE;

    `include "tbVectors.svh"

    logic               clk;
    logic               rstN;
    saCfgPkg::shiftT    cfgShift;
    saCfgPkg::zpT       cfgZp;
    logic               actInVld;
    logic               actInChnLast;
    saDataPkg::actT     actIn;
    logic               actInRdy;
    logic               actOutVld;
    logic               actOutChnLast;
    saDataPkg::actT     actOut;
    logic               actOutRdy;
    logic [NumPe-1:0]   wgtVld;
    saDataPkg::wgtVecT  wgt;
    logic [NumPe-1:0]   wgtRdy;
    logic               psumVld;
    saDataPkg::qOutT    psumQ;
    saDataPkg::peIdxT   psumIdx;
    logic               psumRdy;

    // Scoreboard state shared by driver and monitors
    int                 curVec;
    int                 resCount;
    int                 actOutCount;
    int                 errCount;
    int                 testCount;
    int                 badTests;
    saDataPkg::actT     expActQ [$];
    logic               expLastQ [$];

    systolicRowTop systolicRowTop_i (
        .clk           (clk),
        .rstN          (rstN),
        .cfgShift      (cfgShift),
        .cfgZp         (cfgZp),
        .actInVld      (actInVld),
        .actInChnLast  (actInChnLast),
        .actIn         (actIn),
        .actInRdy      (actInRdy),
        .actOutVld     (actOutVld),
        .actOutChnLast (actOutChnLast),
        .actOut        (actOut),
        .actOutRdy     (actOutRdy),
        .wgtVld        (wgtVld),
        .wgt           (wgt),
        .wgtRdy        (wgtRdy),
        .psumVld       (psumVld),
        .psumQ         (psumQ),
        .psumIdx       (psumIdx),
        .psumRdy       (psumRdy)
    );

    always #5 clk = ~clk;

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic checkQOut(input string name, input saDataPkg::qOutT expVal,
                             input saDataPkg::qOutT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s psumQ expected %0d actual %0d", name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic checkAct(input string name, input saDataPkg::actT expVal,
                            input saDataPkg::actT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s actOut expected %0d actual %0d", name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic checkIdx(input string name, input saDataPkg::peIdxT expVal,
                            input saDataPkg::peIdxT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s psumIdx expected %0d actual %0d", name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic checkFlag(input string name, input string sig, input logic expVal,
                             input logic actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s %s expected %0b actual %0b", name, sig, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCount++;
        if (errCount == errBefore) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errCount - errBefore);
            badTests++;
        end
    endtask

    // ============================================================
    // Monitors sample 1 ns after the falling edge
    // ============================================================
    always begin
        @(negedge clk);
        #1;
        if (rstN && psumVld && psumRdy) begin
            if (resCount >= NumPe) begin
                $display("%s: more results than elements in one window", vecName[curVec]);
                errCount++;
            end else begin
                // Elements close west to east and round robin drains them in index order
                checkIdx(vecName[curVec], saDataPkg::peIdxT'(resCount), psumIdx);
                checkQOut(vecName[curVec], vecTable[curVec].expQ[resCount], psumQ);
            end
            resCount++;
        end
    end

    always begin
        @(negedge clk);
        #1;
        if (rstN && actOutVld && actOutRdy) begin
            if (expActQ.size() == 0) begin
                $display("%s: activation at actOut with none outstanding", vecName[curVec]);
                errCount++;
            end else begin
                checkAct(vecName[curVec], expActQ.pop_front(), actOut);
                checkFlag(vecName[curVec], "actOutChnLast", expLastQ.pop_front(),
                          actOutChnLast);
            end
            actOutCount++;
        end
    end

    // ============================================================
    // Driver for one window
    // ============================================================
    task automatic runWindow(input int v);
        int               len;
        int               actPos;
        int               wgtPos [NumPe];
        int               errBefore;
        logic             actTaken;
        logic [NumPe-1:0] wgtTaken;
        logic             done;
        len       = int'(vecTable[v].len);
        errBefore = errCount;
        actPos    = 0;
        actTaken  = 1'b0;
        wgtTaken  = '0;
        done      = 1'b0;
        foreach (wgtPos[i]) begin
            wgtPos[i] = 0;
        end
        @(negedge clk);
        curVec      = v;
        resCount    = 0;
        actOutCount = 0;
        cfgShift    = vecTable[v].shift;
        cfgZp       = vecTable[v].zp;
        while (!done) begin
            actInVld     = (actPos < len);
            actInChnLast = (actPos == len - 1);
            if (actPos < len) begin
                actIn = vecTable[v].act[8*actPos +: 8];
            end else begin
                actIn = '0;
            end
            for (int i = 0; i < NumPe; i++) begin
                wgtVld[i] = (wgtPos[i] < len);
                if (wgtPos[i] < len) begin
                    wgt[i] = vecTable[v].wgt[i][8*wgtPos[i] +: 8];
                end else begin
                    wgt[i] = '0;
                end
            end
            // Random back-pressure on one cycle in three
            psumRdy   = vecTable[v].stall[0] ? ($urandom % 3 != 0) : 1'b1;
            actOutRdy = vecTable[v].stall[1] ? ($urandom % 3 != 0) : 1'b1;
            #1;
            actTaken = actInVld && actInRdy;
            wgtTaken = wgtVld & wgtRdy;
            if (actTaken) begin
                expActQ.push_back(actIn);
                expLastQ.push_back(actInChnLast);
            end
            @(negedge clk);
            if (actTaken) begin
                actPos++;
            end
            for (int i = 0; i < NumPe; i++) begin
                if (wgtTaken[i]) begin
                    wgtPos[i]++;
                end
            end
            done = (resCount == NumPe) && (actOutCount == len);
        end
        reportTest(vecName[v], errBefore);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        void'($urandom(32'hc4a0bcb4));
        clk          = 1'b0;
        rstN         = 1'b0;
        cfgShift     = '0;
        cfgZp        = '0;
        actInVld     = 1'b0;
        actInChnLast = 1'b0;
        actIn        = '0;
        actOutRdy    = 1'b0;
        wgtVld       = '0;
        wgt          = '0;
        psumRdy      = 1'b0;
        curVec       = 0;
        resCount     = 0;
        actOutCount  = 0;
        errCount     = 0;
        testCount    = 0;
        badTests     = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        #1;
        checkFlag("reset", "actOutVld", 1'b0, actOutVld);
        checkFlag("reset", "psumVld", 1'b0, psumVld);
        reportTest("reset", 0);
        for (int v = 0; v < NumVec; v++) begin
            runWindow(v);
        end
        $display("Summary: %0d tests, %0d with errors, %0d failed checks",
                 testCount, badTests, errCount);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog scaled to the total activation count
    initial begin
        int limit;
        limit = 0;
        for (int v = 0; v < NumVec; v++) begin
            limit += int'(vecTable[v].len);
        end
        limit = limit * NumPe * 40;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
+incdir+testbench
src/saDataPkg.sv
src/saCfgPkg.sv
src/actStreamIf.sv
src/actInputFifo.sv
src/processingElement.sv
src/peRow.sv
src/psumRequant.sv
src/systolicRowTop.sv
testbench/tbSystolicRow.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the systolic row testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tbSystolicRow \
    -Mdir "$OBJ" -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides pass or fail
if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
